//--- sources.f
+incdir+tb
design/muldiv_pkg.sv
design/muldiv_decode.sv
design/muldiv.sv
design/muldiv_unit.sv
tb/tb_muldiv_unit.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the muldiv unit testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_muldiv_unit \
    -o sim_muldiv

./obj_dir/sim_muldiv | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without a reported failure"
exit 0

//--- tb/muldiv_ref.svh
`ifndef MULDIV_REF_SVH
`define MULDIV_REF_SVH

// Expected response of the unit to one request, built directly from the M-extension rules.
// Word-form high multiplies have no encoding and come back as an error with a zero result.
function automatic void muldiv_ref(
    input  funct3_t f3,
    input  logic    word,
    input  xlen_t   a,
    input  xlen_t   b,
    output xlen_t   res,
    output logic    err
);
    logic        [2*XLEN-1:0]     product;
    logic signed [XLEN-1:0]       sa;
    logic signed [XLEN-1:0]       sb;
    logic signed [XLEN-1:0]       sq;
    logic signed [XLEN-1:0]       sr;
    logic signed [WORD_WIDTH-1:0] swa;
    logic signed [WORD_WIDTH-1:0] swb;
    logic signed [WORD_WIDTH-1:0] swq;
    logic signed [WORD_WIDTH-1:0] swr;
    logic        [WORD_WIDTH-1:0] wres;
    logic                         ovf;

    res = '0;
    err = 1'b0;
    sa = a;
    sb = b;
    sq = '0;
    sr = '0;
    swa = a[WORD_WIDTH-1:0];
    swb = b[WORD_WIDTH-1:0];
    swq = '0;
    swr = '0;
    wres = '0;
    if (word) begin
        ovf = (a[WORD_WIDTH-1:0] == 32'h8000_0000) && (b[WORD_WIDTH-1:0] == 32'hffff_ffff);
        // Signed quotient and remainder of the ordinary case.
        if (swb != 0 && !ovf) begin
            swq = swa / swb;
            swr = swa % swb;
        end
        case (f3)
            F3_MUL:  wres = a[WORD_WIDTH-1:0] * b[WORD_WIDTH-1:0];
            F3_DIV:  wres = (swb == 0) ? '1 : (ovf ? swa : swq);
            F3_DIVU: wres = (swb == 0) ? '1 : a[WORD_WIDTH-1:0] / b[WORD_WIDTH-1:0];
            F3_REM:  wres = (swb == 0) ? swa : (ovf ? '0 : swr);
            F3_REMU: wres = (swb == 0) ? swa : a[WORD_WIDTH-1:0] % b[WORD_WIDTH-1:0];
            default: err = 1'b1;
        endcase
        // Every word result, unsigned ones too, is sign-extended from bit 31.
        res = {{(XLEN - WORD_WIDTH){wres[WORD_WIDTH-1]}}, wres};
    end else begin
        ovf = (a == {1'b1, {(XLEN - 1){1'b0}}}) && (b == '1);
        // Signed quotient and remainder of the ordinary case.
        if (b != '0 && !ovf) begin
            sq = sa / sb;
            sr = sa % sb;
        end
        case (f3)
            F3_MUL:    res = a * b;
            F3_MULH:   product = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
            F3_MULHSU: product = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{1'b0}}, b};
            F3_MULHU:  product = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
            F3_DIV:    res = (b == '0) ? '1 : (ovf ? a : sq);
            F3_DIVU:   res = (b == '0) ? '1 : a / b;
            F3_REM:    res = (b == '0) ? a : (ovf ? '0 : sr);
            default:   res = (b == '0) ? a : a % b;
        endcase
        if (f3 == F3_MULH || f3 == F3_MULHSU || f3 == F3_MULHU) begin
            res = product[2*XLEN-1:XLEN];
        end
    end
endfunction

`endif

//--- tb/tb_muldiv_unit.sv
`timescale 1ns/1ns

module tb_muldiv_unit;
    import muldiv_pkg::*;

    `include "muldiv_ref.svh"

    localparam int CLK_PERIOD = 8;
    localparam int NUM_CORNERS = 9;
    localparam int RANDOM_PER_OP = 20;
    localparam int BURST_LEN = 500;
    // Corner sweep, random sweep, special divides, illegal requests and the burst.
    localparam int TOTAL_REQUESTS = 13 * NUM_CORNERS * NUM_CORNERS + 13 * RANDOM_PER_OP
                                    + 32 + 12 + BURST_LEN;
    localparam xlen_t CORNERS [NUM_CORNERS] = '{
        64'h0, 64'h1, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
        64'h7fff_ffff_ffff_ffff, 64'h0000_0000_8000_0000, 64'h0000_0000_7fff_ffff,
        64'hffff_ffff_8000_0000, 64'h0000_0000_ffff_ffff
    };

    logic    clock;
    logic    rst_n;
    logic    op_valid;
    funct3_t funct3;
    logic    is_word;
    xlen_t   src1;
    xlen_t   src2;
    logic    result_valid;
    xlen_t   result;
    logic    op_error;

    xlen_t exp_result_q[$];
    logic  exp_error_q[$];
    logic  prev_op_valid;
    int    error_count;
    int    tests_passed;
    int    tests_failed;
    int    test_start_errors;

    muldiv_unit u_dut (
        .clock        (clock),
        .rst_n        (rst_n),
        .op_valid     (op_valid),
        .funct3       (funct3),
        .is_word      (is_word),
        .src1         (src1),
        .src2         (src2),
        .result_valid (result_valid),
        .result       (result),
        .op_error     (op_error)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic check_result(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_error(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: expected %b, got %b", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        error_count++;
    endtask

    task automatic send_request(input funct3_t f3, input logic word, input xlen_t a, input xlen_t b);
        xlen_t exp_res;
        logic  exp_err;
        @(negedge clock);
        op_valid = 1'b1;
        funct3 = f3;
        is_word = word;
        src1 = a;
        src2 = b;
        muldiv_ref(f3, word, a, b, exp_res, exp_err);
        exp_result_q.push_back(exp_res);
        exp_error_q.push_back(exp_err);
    endtask

    task automatic idle_cycle();
        @(negedge clock);
        op_valid = 1'b0;
    endtask

    function automatic xlen_t random_operand();
        // Now and then a corner value, so the burst also crosses the special cases.
        if ($urandom % 4 == 0) begin
            return CORNERS[$urandom % NUM_CORNERS];
        end
        return {$urandom, $urandom};
    endfunction

    // Lets the pipeline drain and then scores the test.
    task automatic finish_test(input string name);
        idle_cycle();
        while (exp_result_q.size() != 0) @(posedge clock);
        @(negedge clock);
        if (error_count == test_start_errors) begin
            tests_passed++;
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    // Each result belongs to the request seen on the previous rising edge.
    always @(posedge clock) begin
        if (!rst_n) begin
            prev_op_valid = 1'b0;
        end else begin
            if (result_valid && !prev_op_valid) begin
                report_failure("result_valid rose without a request on the cycle before");
            end else if (result_valid && exp_result_q.size() == 0) begin
                report_failure("result_valid rose with no expected result queued");
            end else if (result_valid) begin
                check_result("result", exp_result_q.pop_front(), result);
                check_error("op_error", exp_error_q.pop_front(), op_error);
            end else if (prev_op_valid) begin
                report_failure("result_valid missing one cycle after a request");
                void'(exp_result_q.pop_front());
                void'(exp_error_q.pop_front());
            end else begin
                check_error("op_error", 1'b0, op_error);
            end
            prev_op_valid = op_valid;
        end
    end

    initial begin
        #((TOTAL_REQUESTS + 200) * CLK_PERIOD);
        $display("Watchdog expired with %0d results still outstanding", exp_result_q.size());
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        void'($urandom(90));
        clock = 1'b0;
        rst_n = 1'b0;
        op_valid = 1'b0;
        funct3 = F3_MUL;
        is_word = 1'b0;
        src1 = '0;
        src2 = '0;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_start_errors = 0;
        repeat (4) @(negedge clock);
        rst_n = 1'b1;

        repeat (5) begin
            @(negedge clock);
            check_error("result_valid", 1'b0, result_valid);
            check_error("op_error", 1'b0, op_error);
            check_result("result", '0, result);
        end
        finish_test("reset_quiet");

        // The 13 legal operations are every funct3 code except the word-form high multiplies.
        for (int w = 0; w < 2; w++) begin
            for (int f = 0; f < 8; f++) begin
                if (w == 1 && f >= 1 && f <= 3) continue;
                for (int i = 0; i < NUM_CORNERS; i++) begin
                    for (int j = 0; j < NUM_CORNERS; j++) begin
                        send_request(funct3_t'(f), w == 1, CORNERS[i], CORNERS[j]);
                    end
                end
                for (int k = 0; k < RANDOM_PER_OP; k++) begin
                    send_request(funct3_t'(f), w == 1, {$urandom, $urandom}, {$urandom, $urandom});
                end
            end
        end
        finish_test("legal_ops");

        // A word divisor is zero when its low half is, whatever the upper half holds.
        for (int w = 0; w < 2; w++) begin
            for (int f = 4; f < 8; f++) begin
                send_request(funct3_t'(f), w == 1, CORNERS[3], w ? 64'hdead_beef_0000_0000 : '0);
                send_request(funct3_t'(f), w == 1, 64'd5, w ? 64'hdead_beef_0000_0000 : '0);
                send_request(funct3_t'(f), w == 1, -64'd7, w ? 64'hdead_beef_0000_0000 : '0);
            end
            for (int f = 4; f < 8; f += 2) begin
                send_request(funct3_t'(f), w == 1, CORNERS[3], '1);
                send_request(funct3_t'(f), w == 1, 64'h1234_5678_8000_0000, CORNERS[8]);
            end
        end
        finish_test("div_zero_overflow");

        for (int f = 1; f <= 3; f++) begin
            repeat (4) send_request(funct3_t'(f), 1'b1, {$urandom, $urandom}, {$urandom, $urandom});
        end
        finish_test("illegal_word_mulh");

        for (int n = 0; n < BURST_LEN; n++) begin
            if ($urandom % 16 == 0) idle_cycle();
            send_request(funct3_t'($urandom % 8), 1'($urandom % 2), random_operand(),
                         random_operand());
        end
        finish_test("burst");

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- design/muldiv_unit.sv
`timescale 1ns/1ns

module muldiv_unit (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                op_valid,
    input  muldiv_pkg::funct3_t funct3,
    input  logic                is_word,
    input  muldiv_pkg::xlen_t   src1,
    input  muldiv_pkg::xlen_t   src2,
    output logic                result_valid,
    output muldiv_pkg::xlen_t   result,
    output logic                op_error
);
    import muldiv_pkg::*;

    muldiv_type_t muldiv_type;
    logic         illegal;
    xlen_t        alu_result;

    // Decode is gated by op_valid, so idle cycles select no operation.
    muldiv_decode u_decode (
        .funct3      (funct3),
        .is_word     (is_word),
        .op_valid    (op_valid),
        .muldiv_type (muldiv_type),
        .illegal     (illegal)
    );

    muldiv u_muldiv (
        .clock       (clock),
        .src1        (src1),
        .src2        (src2),
        .muldiv_type (muldiv_type),
        .result      (alu_result)
    );

    // Single output register stage. Every request is answered on the next edge
    // and the unit never stalls.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            op_error     <= 1'b0;
            result       <= '0;
        end else begin
            result_valid <= op_valid;
            op_error     <= op_valid & illegal;
            if (op_valid) begin
                // An illegal request returns zero rather than whatever the
                // arithmetic block happens to produce.
                result <= illegal ? '0 : alu_result;
            end
        end
    end

    // An error is reported only as part of a valid response.
    a_error_has_valid: assert property (
        @(posedge clock) disable iff (!rst_n)
        op_error |-> result_valid
    ) else $error("muldiv_unit: op_error without result_valid");

endmodule

//--- design/muldiv.sv
`timescale 1ns/1ns

module muldiv (
    input  logic                     clock,
    input  muldiv_pkg::xlen_t        src1,
    input  muldiv_pkg::xlen_t        src2,
    input  muldiv_pkg::muldiv_type_t muldiv_type,
    output muldiv_pkg::xlen_t        result
);
    import muldiv_pkg::*;

    // Sign-extends a 32-bit value to the full register width.
    function automatic xlen_t sext_word(input logic [WORD_WIDTH-1:0] w);
        return {{(XLEN - WORD_WIDTH){w[WORD_WIDTH-1]}}, w};
    endfunction

    // Zero-extends a 32-bit value to the full register width.
    function automatic xlen_t zext_word(input logic [WORD_WIDTH-1:0] w);
        return {{(XLEN - WORD_WIDTH){1'b0}}, w};
    endfunction

    logic is_mul;
    logic is_mulh;
    logic is_mulhsu;
    logic is_mulhu;
    logic is_div;
    logic is_divu;
    logic is_rem;
    logic is_remu;
    logic is_mulw;
    logic is_divw;
    logic is_divuw;
    logic is_remw;
    logic is_remuw;

    assign is_mul    = muldiv_type[OP_MUL];
    assign is_mulh   = muldiv_type[OP_MULH];
    assign is_mulhsu = muldiv_type[OP_MULHSU];
    assign is_mulhu  = muldiv_type[OP_MULHU];
    assign is_div    = muldiv_type[OP_DIV];
    assign is_divu   = muldiv_type[OP_DIVU];
    assign is_rem    = muldiv_type[OP_REM];
    assign is_remu   = muldiv_type[OP_REMU];
    assign is_mulw   = muldiv_type[OP_MULW];
    assign is_divw   = muldiv_type[OP_DIVW];
    assign is_divuw  = muldiv_type[OP_DIVUW];
    assign is_remw   = muldiv_type[OP_REMW];
    assign is_remuw  = muldiv_type[OP_REMUW];

    // A single unsigned 64x64 multiplier serves every multiply.
    // Signed high halves are recovered by subtracting the other operand once
    // for each negative operand, which is exact modulo 2^64.
    logic [2*XLEN-1:0] prod_uu;
    xlen_t             prod_hi_uu;
    xlen_t             corr_src1_neg;
    xlen_t             corr_src2_neg;
    xlen_t             prod_hi_ss;
    xlen_t             prod_hi_su;
    xlen_t             mulw_result;

    assign prod_uu       = {{XLEN{1'b0}}, src1} * {{XLEN{1'b0}}, src2};
    assign prod_hi_uu    = prod_uu[2*XLEN-1:XLEN];
    assign corr_src1_neg = src1[XLEN-1] ? src2 : '0;
    assign corr_src2_neg = src2[XLEN-1] ? src1 : '0;
    assign prod_hi_ss    = prod_hi_uu - corr_src1_neg - corr_src2_neg;
    assign prod_hi_su    = prod_hi_uu - corr_src1_neg;

    // The low 32 bits of a product depend only on the low 32 bits of the operands.
    assign mulw_result = sext_word(prod_uu[WORD_WIDTH-1:0]);

    // Divider operand preparation. Word operations extend their low halves
    // to 64 bits, so one divider covers both widths.
    logic  div_word;
    logic  div_signed;
    xlen_t dividend;
    xlen_t divisor;

    assign div_word   = is_divw | is_divuw | is_remw | is_remuw;
    assign div_signed = is_div | is_rem | is_divw | is_remw;

    always_comb begin
        if (!div_word) begin
            dividend = src1;
            divisor  = src2;
        end else if (div_signed) begin
            dividend = sext_word(src1[WORD_WIDTH-1:0]);
            divisor  = sext_word(src2[WORD_WIDTH-1:0]);
        end else begin
            dividend = zext_word(src1[WORD_WIDTH-1:0]);
            divisor  = zext_word(src2[WORD_WIDTH-1:0]);
        end
    end

    // Special cases from the ISA. The most negative value depends on the width.
    logic  div_by_zero;
    logic  overflow;
    xlen_t min_value;

    assign min_value   = div_word ? sext_word({1'b1, {(WORD_WIDTH - 1){1'b0}}})
                                  : {1'b1, {(XLEN - 1){1'b0}}};
    assign div_by_zero = (divisor == '0);
    assign overflow    = div_signed && (dividend == min_value) && (divisor == '1);

    // Signed division runs on magnitudes and fixes the signs afterwards.
    // The quotient truncates toward zero and the remainder follows the dividend.
    logic  dividend_neg;
    logic  divisor_neg;
    xlen_t dividend_mag;
    xlen_t divisor_mag;
    xlen_t divisor_safe;
    xlen_t quot_mag;
    xlen_t rem_mag;
    xlen_t quotient;
    xlen_t remainder;

    assign dividend_neg = div_signed & dividend[XLEN-1];
    assign divisor_neg  = div_signed & divisor[XLEN-1];
    assign dividend_mag = dividend_neg ? -dividend : dividend;
    assign divisor_mag  = divisor_neg ? -divisor : divisor;
    // Keeps the divider away from a zero divisor. Its output is unused then.
    assign divisor_safe = div_by_zero ? xlen_t'(1) : divisor_mag;
    assign quot_mag     = dividend_mag / divisor_safe;
    assign rem_mag      = dividend_mag % divisor_safe;

    always_comb begin
        if (div_by_zero) begin
            quotient  = '1;
            remainder = dividend;
        end else if (overflow) begin
            quotient  = dividend;
            remainder = '0;
        end else begin
            quotient  = (dividend_neg ^ divisor_neg) ? -quot_mag : quot_mag;
            remainder = dividend_neg ? -rem_mag : rem_mag;
        end
    end

    // AND-OR select. An all-zero vector yields a zero result.
    always_comb begin
        result = '0;
        if (is_mul) begin
            result |= prod_uu[XLEN-1:0];
        end
        if (is_mulh) begin
            result |= prod_hi_ss;
        end
        if (is_mulhsu) begin
            result |= prod_hi_su;
        end
        if (is_mulhu) begin
            result |= prod_hi_uu;
        end
        if (is_div || is_divu) begin
            result |= quotient;
        end
        if (is_rem || is_remu) begin
            result |= remainder;
        end
        if (is_mulw) begin
            result |= mulw_result;
        end
        // Unsigned word results are sign-extended from bit 31 as well.
        if (is_divw || is_divuw) begin
            result |= sext_word(quotient[WORD_WIDTH-1:0]);
        end
        if (is_remw || is_remuw) begin
            result |= sext_word(remainder[WORD_WIDTH-1:0]);
        end
    end

    // More than one select bit would OR two results together.
    a_type_onehot: assert property (@(posedge clock) $onehot0(muldiv_type))
    else $error("muldiv: more than one operation selected, %b", muldiv_type);

endmodule

//--- design/muldiv_decode.sv
`timescale 1ns/1ns

module muldiv_decode (
    input  muldiv_pkg::funct3_t      funct3,
    input  logic                     is_word,
    input  logic                     op_valid,
    output muldiv_pkg::muldiv_type_t muldiv_type,
    output logic                     illegal
);
    import muldiv_pkg::*;

    // The vector stays all zeros unless a request is present, so the
    // arithmetic block sees no operation on idle cycles.
    always_comb begin
        muldiv_type = '0;
        illegal     = 1'b0;
        if (op_valid) begin
            if (is_word) begin
                // OP-32 space. There are no word forms of the high-half multiplies.
                case (funct3)
                    F3_MUL: begin
                        muldiv_type[OP_MULW] = 1'b1;
                    end
                    F3_MULH, F3_MULHSU, F3_MULHU: begin
                        illegal = 1'b1;
                    end
                    F3_DIV: begin
                        muldiv_type[OP_DIVW] = 1'b1;
                    end
                    F3_DIVU: begin
                        muldiv_type[OP_DIVUW] = 1'b1;
                    end
                    F3_REM: begin
                        muldiv_type[OP_REMW] = 1'b1;
                    end
                    F3_REMU: begin
                        muldiv_type[OP_REMUW] = 1'b1;
                    end
                endcase
            end else begin
                // OP space, every funct3 code is a legal 64-bit operation.
                case (funct3)
                    F3_MUL: begin
                        muldiv_type[OP_MUL] = 1'b1;
                    end
                    F3_MULH: begin
                        muldiv_type[OP_MULH] = 1'b1;
                    end
                    F3_MULHSU: begin
                        muldiv_type[OP_MULHSU] = 1'b1;
                    end
                    F3_MULHU: begin
                        muldiv_type[OP_MULHU] = 1'b1;
                    end
                    F3_DIV: begin
                        muldiv_type[OP_DIV] = 1'b1;
                    end
                    F3_DIVU: begin
                        muldiv_type[OP_DIVU] = 1'b1;
                    end
                    F3_REM: begin
                        muldiv_type[OP_REM] = 1'b1;
                    end
                    F3_REMU: begin
                        muldiv_type[OP_REMU] = 1'b1;
                    end
                endcase
            end
        end
    end

    // An illegal request must reach the arithmetic block as no operation at all,
    // and a legal one must select exactly one result path.
    always_comb begin
        assert ($onehot0(muldiv_type) && !(illegal && (|muldiv_type)))
        else $error("muldiv_decode: bad operation vector %b (illegal=%b)",
                    muldiv_type, illegal);
    end

endmodule

//--- design/muldiv_pkg.sv
package muldiv_pkg;

    // Operand and result width of the RV64 integer datapath.
    localparam int XLEN = 64;

    // W-suffixed operations work on the low half of each operand.
    localparam int WORD_WIDTH = 32;

    // One bit per M-extension operation in the one-hot vector.
    localparam int MULDIV_TYPE_WIDTH = 13;

    // Bit positions in the one-hot operation vector.
    localparam int OP_MUL    = 0;
    localparam int OP_MULH   = 1;
    localparam int OP_MULHSU = 2;
    localparam int OP_MULHU  = 3;
    localparam int OP_DIV    = 4;
    localparam int OP_DIVU   = 5;
    localparam int OP_REM    = 6;
    localparam int OP_REMU   = 7;
    localparam int OP_MULW   = 8;
    localparam int OP_DIVW   = 9;
    localparam int OP_DIVUW  = 10;
    localparam int OP_REMW   = 11;
    localparam int OP_REMUW  = 12;

    // A full operand or result word.
    typedef logic [XLEN-1:0] xlen_t;

    // One-hot operation select, all zeros when no operation is active.
    typedef logic [MULDIV_TYPE_WIDTH-1:0] muldiv_type_t;

    // The funct3 field of an OP or OP-32 instruction with funct7 = 0000001.
    typedef logic [2:0] funct3_t;

    // The funct3 encodings of the M extension.
    // The same codes select the W variant when the word flag is set.
    localparam funct3_t F3_MUL    = 3'd0;
    localparam funct3_t F3_MULH   = 3'd1;
    localparam funct3_t F3_MULHSU = 3'd2;
    localparam funct3_t F3_MULHU  = 3'd3;
    localparam funct3_t F3_DIV    = 3'd4;
    localparam funct3_t F3_DIVU   = 3'd5;
    localparam funct3_t F3_REM    = 3'd6;
    localparam funct3_t F3_REMU   = 3'd7;

endpackage
